// ==== cachePkg.sv ====
`default_nettype none

package cachePkg;

  // fetch side geometry
  localparam int addrWidth = 32;
  localparam int wordWidth = 64;
  localparam int wordsPerLine = 4;
  localparam int numSets = 64;

  // byte offset inside a line, then set index, then tag
  localparam int offsetBits = $clog2(wordsPerLine * wordWidth / 8);
  localparam int indexBits = $clog2(numSets);
  localparam int tagBits = addrWidth - indexBits - offsetBits;

  // upper offset bits pick the word inside a line
  localparam int wordSelBits = $clog2(wordsPerLine);

  typedef logic [addrWidth-1:0] addrT;
  typedef logic [wordWidth-1:0] wordT;
  typedef logic [wordsPerLine*wordWidth-1:0] lineT;
  typedef logic [indexBits-1:0] indexT;
  typedef logic [tagBits-1:0] tagT;
  typedef logic [wordSelBits-1:0] wordSelT;

endpackage

`default_nettype wire

// ==== busPkg.sv ====
`default_nettype none

package busPkg;

  // refill read port, one line per burst
  localparam int beatWidth = 64;
  localparam int beatsPerBurst = 4;

  typedef logic [beatWidth-1:0] beatT;

  // wraps after the last beat of a burst
  typedef logic [$clog2(beatsPerBurst)-1:0] beatCntT;

endpackage

`default_nettype wire

// ==== syncRam.sv ====
`default_nettype none
`timescale 1ns/1ps

module syncRam #(
  parameter type entryT = logic
) (
  input  wire             clk,
  input  wire             en_i,
  input  wire             we_i,
  input  wire             cachePkg::indexT index_i,
  input  wire             entryT wrData_i,
  output entryT           rdData_o
);

  entryT mem [cachePkg::numSets];

  // one access per cycle, read data shows up after the edge
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem[index_i] <= wrData_i;
      end else begin
        rdData_o <= mem[index_i];
      end
    end
  end

  // the controller must always hand over a clean set index
  indexKnown: assert property (
    @(posedge clk) en_i |-> !$isunknown(index_i)
  );

endmodule

`default_nettype wire

// ==== hitSelect.sv ====
`default_nettype none
`timescale 1ns/1ps

module hitSelect (
  input  wire                cachePkg::tagT tagWay0_i,
  input  wire                cachePkg::tagT tagWay1_i,
  input  wire                cachePkg::lineT lineWay0_i,
  input  wire                cachePkg::lineT lineWay1_i,
  input  wire  [1:0]         valid_i,
  input  wire                cachePkg::tagT reqTag_i,
  input  wire                cachePkg::wordSelT reqWord_i,
  output logic               hit_o,
  output logic               hitWay_o,
  output cachePkg::wordT     word_o
);

  logic hitWay0;
  logic hitWay1;
  cachePkg::lineT hitLine;

  // a stale tag never matches while its valid bit is low
  assign hitWay0 = valid_i[0] && (tagWay0_i == reqTag_i);
  assign hitWay1 = valid_i[1] && (tagWay1_i == reqTag_i);

  assign hit_o = hitWay0 || hitWay1;
  assign hitWay_o = hitWay1;

  // line of the hitting way, way 0 otherwise
  assign hitLine = hitWay1 ? lineWay1_i : lineWay0_i;

  assign word_o = hitLine[reqWord_i*cachePkg::wordWidth +: cachePkg::wordWidth];

  // fill policy only loads a tag that missed in both ways,
  // so one set never holds the same tag twice
  always_comb begin
    bothWays: assert final (!(hitWay0 && hitWay1));
  end

endmodule

`default_nettype wire

// ==== refillBuffer.sv ====
`default_nettype none
`timescale 1ns/1ps

module refillBuffer (
  input  wire              clk,
  input  wire              rst_n,
  input  wire              clear_i,
  input  wire              beatValid_i,
  input  wire              busPkg::beatT beat_i,
  output cachePkg::lineT   line_o
);

  busPkg::beatCntT beatCnt;
  logic full;
  logic capture;

  // beats past a complete line are dropped
  assign capture = beatValid_i && !full;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
      full <= 1'b0;
    end else if (clear_i) begin
      beatCnt <= '0;
      full <= 1'b0;
    end else if (capture) begin
      beatCnt <= beatCnt + busPkg::beatCntT'(1);
      if (beatCnt == busPkg::beatCntT'(busPkg::beatsPerBurst - 1)) begin
        full <= 1'b1;
      end
    end
  end

  // beat n lands in word n of the line
  always_ff @(posedge clk) begin
    if (capture) begin
      line_o[beatCnt*busPkg::beatWidth +: busPkg::beatWidth] <= beat_i;
    end
  end

  // memory side returns exactly one burst per refill request
  burstLength: assert property (
    @(posedge clk) disable iff (!rst_n)
    beatValid_i |-> !full
  );

endmodule

`default_nettype wire

// ==== icacheCtrl.sv ====
`default_nettype none
`timescale 1ns/1ps

module icacheCtrl (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  cachePkg::addrT addr_i,
  input  wire                  valid_i,
  input  wire                  stallN_i,
  output logic                 addrOk_o,
  output logic                 dataOk_o,
  output logic                 dataNotOk_o,
  output logic                 refillValid_o,
  output cachePkg::addrT       refillAddr_o,
  input  wire                  rdReady_i,
  input  wire                  rdLast_i,
  input  wire                  hit_i,
  input  wire                  hitWay_i,
  output logic                 ramEn_o,
  output logic [1:0]           ramWe_o,
  output cachePkg::indexT      ramIndex_o,
  output cachePkg::tagT        reqTag_o,
  output cachePkg::wordSelT    reqWord_o,
  output logic [1:0]           valid_o,
  output logic                 refillClear_o
);

  typedef enum logic [2:0] {
    sIdle,
    sCompare,
    sMiss,
    sRefill,
    sReplace,
    sReread
  } stateT;

  stateT state;
  stateT nextState;
  cachePkg::addrT reqAddr;
  cachePkg::indexT reqIndex;
  logic [cachePkg::numSets-1:0] validWay0;
  logic [cachePkg::numSets-1:0] validWay1;
  logic [7:0] lfsr;
  logic victimWay;
  logic fillWay;
  logic accept;

  // fields of the latched request
  assign reqIndex = reqAddr[cachePkg::offsetBits +: cachePkg::indexBits];
  assign reqTag_o = reqAddr[cachePkg::addrWidth-1 -: cachePkg::tagBits];
  assign reqWord_o = reqAddr[cachePkg::offsetBits-1 -: cachePkg::wordSelBits];

  assign addrOk_o = (state == sIdle) || (state == sCompare && hit_i);
  assign accept = valid_i && stallN_i && addrOk_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= sIdle;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      sIdle: begin
        if (accept) begin
          nextState = sCompare;
        end
      end
      sCompare: begin
        if (!hit_i) begin
          nextState = sMiss;
        end else if (!accept) begin
          nextState = sIdle;
        end
      end
      sMiss: begin
        if (rdReady_i) begin
          nextState = sRefill;
        end
      end
      sRefill: begin
        if (rdLast_i) begin
          nextState = sReplace;
        end
      end
      // line is written, then read back before answering
      sReplace: nextState = sReread;
      sReread: nextState = sCompare;
      default: nextState = sIdle;
    endcase
  end

  // held while stalled or waiting on a miss
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reqAddr <= '0;
    end else if (accept) begin
      reqAddr <= addr_i;
    end
  end

  // free running, x^8 + x^6 + x^5 + x^4 + 1
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsr <= 8'h5a;
    end else begin
      lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
    end
  end

  // empty way first, random way when the set is full
  always_comb begin
    if (!validWay0[reqIndex]) begin
      victimWay = 1'b0;
    end else if (!validWay1[reqIndex]) begin
      victimWay = 1'b1;
    end else begin
      victimWay = lfsr[0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validWay0 <= '0;
      validWay1 <= '0;
      fillWay <= 1'b0;
    end else if (state == sReplace) begin
      fillWay <= victimWay;
      if (victimWay) begin
        validWay1[reqIndex] <= 1'b1;
      end else begin
        validWay0[reqIndex] <= 1'b1;
      end
    end
  end

  assign valid_o = {validWay1[reqIndex], validWay0[reqIndex]};

  // RAM strobes, a new request addresses the RAMs directly
  assign ramEn_o = accept || state == sReplace || state == sReread;
  assign ramWe_o = (state == sReplace) ? {victimWay, !victimWay} : 2'b00;
  assign ramIndex_o = accept ? addr_i[cachePkg::offsetBits +: cachePkg::indexBits] : reqIndex;

  assign dataOk_o = state == sCompare && hit_i;
  assign dataNotOk_o = (state == sCompare && !hit_i) || state == sMiss ||
                       state == sRefill || state == sReplace || state == sReread;
  assign refillValid_o = state == sMiss && rdReady_i;
  assign refillAddr_o = {reqTag_o, reqIndex, {cachePkg::offsetBits{1'b0}}};
  assign refillClear_o = state == sCompare && !hit_i;

  rdLastInRefill: assert property (
    @(posedge clk) disable iff (!rst_n)
    rdLast_i |-> state == sRefill
  );

  // the reread after a fill must hit in the way just written
  fillHits: assert property (
    @(posedge clk) disable iff (!rst_n)
    state == sReread |=> hit_i && hitWay_i == fillWay
  );

endmodule

`default_nettype wire

// ==== icacheTop.sv ====
`default_nettype none
`timescale 1ns/1ps

module icacheTop (
  input  wire              clk,
  input  wire              rst_n,
  input  wire              cachePkg::addrT addr_i,
  input  wire              valid_i,
  input  wire              stallN_i,
  output logic             addrOk_o,
  output logic             dataOk_o,
  output logic             dataNotOk_o,
  output cachePkg::wordT   rdData_o,
  output logic             refillValid_o,
  output cachePkg::addrT   refillAddr_o,
  input  wire              rdReady_i,
  input  wire              busPkg::beatT rdData_i,
  input  wire              rdDataValid_i,
  input  wire              rdLast_i
);

  logic ramEn;
  logic [1:0] ramWe;
  cachePkg::indexT ramIndex;
  cachePkg::tagT reqTag;
  cachePkg::wordSelT reqWord;
  logic [1:0] validBits;
  logic refillClear;
  logic hit;
  logic hitWay;
  cachePkg::tagT tagWay0;
  cachePkg::tagT tagWay1;
  cachePkg::lineT lineWay0;
  cachePkg::lineT lineWay1;
  cachePkg::lineT refillLine;

  icacheCtrl ctrl0 (
    .clk(clk), .rst_n(rst_n),
    .addr_i(addr_i), .valid_i(valid_i), .stallN_i(stallN_i),
    .addrOk_o(addrOk_o), .dataOk_o(dataOk_o), .dataNotOk_o(dataNotOk_o),
    .refillValid_o(refillValid_o), .refillAddr_o(refillAddr_o),
    .rdReady_i(rdReady_i), .rdLast_i(rdLast_i),
    .hit_i(hit), .hitWay_i(hitWay),
    .ramEn_o(ramEn), .ramWe_o(ramWe), .ramIndex_o(ramIndex),
    .reqTag_o(reqTag), .reqWord_o(reqWord), .valid_o(validBits),
    .refillClear_o(refillClear)
  );

  // tag RAMs take the request tag on a fill
  syncRam #(.entryT(cachePkg::tagT)) tagRam0 (
    .clk(clk), .en_i(ramEn), .we_i(ramWe[0]), .index_i(ramIndex),
    .wrData_i(reqTag), .rdData_o(tagWay0)
  );

  syncRam #(.entryT(cachePkg::tagT)) tagRam1 (
    .clk(clk), .en_i(ramEn), .we_i(ramWe[1]), .index_i(ramIndex),
    .wrData_i(reqTag), .rdData_o(tagWay1)
  );

  // line RAMs take the assembled refill line
  syncRam #(.entryT(cachePkg::lineT)) lineRam0 (
    .clk(clk), .en_i(ramEn), .we_i(ramWe[0]), .index_i(ramIndex),
    .wrData_i(refillLine), .rdData_o(lineWay0)
  );

  syncRam #(.entryT(cachePkg::lineT)) lineRam1 (
    .clk(clk), .en_i(ramEn), .we_i(ramWe[1]), .index_i(ramIndex),
    .wrData_i(refillLine), .rdData_o(lineWay1)
  );

  hitSelect hitSel0 (
    .tagWay0_i(tagWay0), .tagWay1_i(tagWay1),
    .lineWay0_i(lineWay0), .lineWay1_i(lineWay1),
    .valid_i(validBits), .reqTag_i(reqTag), .reqWord_i(reqWord),
    .hit_o(hit), .hitWay_o(hitWay), .word_o(rdData_o)
  );

  refillBuffer refill0 (
    .clk(clk), .rst_n(rst_n), .clear_i(refillClear),
    .beatValid_i(rdDataValid_i), .beat_i(rdData_i), .line_o(refillLine)
  );

endmodule

`default_nettype wire

// ==== tbMemModel.sv ====
`default_nettype none
`timescale 1ns/1ps

module tbMemModel #(
  parameter busPkg::beatT pattern = '0
) (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  refillValid_i,
  input  wire                  cachePkg::addrT refillAddr_i,
  output logic                 rdReady_o,
  output busPkg::beatT         rdData_o,
  output logic                 rdDataValid_o,
  output logic                 rdLast_o
);

  cachePkg::addrT lineAddr;
  logic busy;
  logic taken;
  int readyDelay;
  int gap;
  int beat;

  // memory content, word address mixed with the pattern
  function automatic busPkg::beatT memWord(cachePkg::addrT byteAddr);
    return busPkg::beatT'(byteAddr >> 3) ^ pattern;
  endfunction

  // everything changes on the falling edge
  initial begin
    rdReady_o = 1'b0;
    rdData_o = '0;
    rdDataValid_o = 1'b0;
    rdLast_o = 1'b0;
    busy = 1'b0;
    taken = 1'b0;
    readyDelay = 0;
    gap = 0;
    beat = 0;
    forever begin
      @(posedge clk);
      // the request is taken at the rising edge that sees both levels
      taken = rdReady_o && refillValid_i;
      if (taken) begin
        lineAddr = refillAddr_i;
      end
      @(negedge clk);
      rdDataValid_o = 1'b0;
      rdLast_o = 1'b0;
      if (!rst_n) begin
        rdReady_o = 1'b0;
        busy = 1'b0;
        readyDelay = 0;
      end else if (busy) begin
        rdReady_o = 1'b0;
        if (gap > 0) begin
          gap--;
        end else begin
          rdData_o = memWord(lineAddr + cachePkg::addrT'(beat * 8));
          rdDataValid_o = 1'b1;
          rdLast_o = (beat == busPkg::beatsPerBurst - 1);
          beat++;
          gap = $urandom() % 3;
          if (beat == busPkg::beatsPerBurst) begin
            busy = 1'b0;
            readyDelay = $urandom() % 4;
          end
        end
      end else if (taken) begin
        rdReady_o = 1'b0;
        beat = 0;
        gap = $urandom() % 3;
        busy = 1'b1;
      end else if (readyDelay > 0) begin
        readyDelay--;
      end else if (!rdReady_o) begin
        rdReady_o = 1'b1;
      end else if ($urandom() % 4 == 0) begin
        // an idle memory is sometimes busy elsewhere for a while
        rdReady_o = 1'b0;
        readyDelay = $urandom() % 3;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tbIcache.sv ====
`default_nettype none
`timescale 1ns/1ps

module tbIcache;

  localparam busPkg::beatT contentPattern = 64'h3c5a_96e1_0f2d_b487;
  localparam int acceptTimeout = 60;
  localparam int drainTimeout = 200;
  localparam int randomFetches = 300;

  logic clk = 1'b0;
  logic rst_n;
  cachePkg::addrT addr;
  logic valid;
  logic stallN;
  logic addrOk;
  logic dataOk;
  logic dataNotOk;
  cachePkg::wordT rdData;
  logic refillValid;
  cachePkg::addrT refillAddr;
  logic rdReady;
  busPkg::beatT memData;
  logic memDataValid;
  logic memLast;

  // accepted fetches still waiting for their answer
  cachePkg::addrT pending[$];
  bit touched[cachePkg::addrT];
  int refillCount = 0;
  cachePkg::addrT lastRefillAddr = '0;
  int notOkCycles = 0;
  int okRun = 0;
  int okRunMax = 0;

  icacheTop dut0 (
    .clk(clk), .rst_n(rst_n),
    .addr_i(addr), .valid_i(valid), .stallN_i(stallN),
    .addrOk_o(addrOk), .dataOk_o(dataOk), .dataNotOk_o(dataNotOk), .rdData_o(rdData),
    .refillValid_o(refillValid), .refillAddr_o(refillAddr),
    .rdReady_i(rdReady), .rdData_i(memData), .rdDataValid_i(memDataValid),
    .rdLast_i(memLast)
  );

  tbMemModel #(.pattern(contentPattern)) mem0 (
    .clk(clk), .rst_n(rst_n),
    .refillValid_i(refillValid), .refillAddr_i(refillAddr),
    .rdReady_o(rdReady), .rdData_o(memData), .rdDataValid_o(memDataValid),
    .rdLast_o(memLast)
  );

  always #50 clk = ~clk;

  // expected instruction word for a fetch address
  function automatic cachePkg::wordT expectedWord(cachePkg::addrT fetchAddr);
    return cachePkg::wordT'(fetchAddr[cachePkg::addrWidth-1:3]) ^ contentPattern;
  endfunction

  function automatic cachePkg::addrT lineOf(cachePkg::addrT fetchAddr);
    return fetchAddr & ~cachePkg::addrT'((1 << cachePkg::offsetBits) - 1);
  endfunction

  task automatic stopRun();
    $display("Some tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic failRun(string why);
    $display("ERROR: %s at %0t", why, $time);
    stopRun();
  endtask

  task automatic checkValue(string name, logic [63:0] actual, logic [63:0] expected);
    if (actual !== expected) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
      stopRun();
    end
  endtask

  // the handshake completes at the rising edge that sees the pulse
  always @(posedge clk) begin
    if (refillValid) begin
      refillCount++;
      lastRefillAddr = refillAddr;
    end
  end

  // each answer belongs to the oldest accepted fetch
  always @(negedge clk) begin
    cachePkg::addrT reqAddr;
    if (dataNotOk) begin
      notOkCycles++;
    end
    if (!dataOk) begin
      okRun = 0;
    end else if (pending.size() == 0) begin
      failRun("dataOk_o raised with no fetch outstanding");
    end else begin
      reqAddr = pending.pop_front();
      checkValue("rdData_o", rdData, expectedWord(reqAddr));
      okRun++;
      if (okRun > okRunMax) begin
        okRunMax = okRun;
      end
    end
  end

  // hold one fetch until the cache takes it, returns on the next falling edge
  task automatic fetch(cachePkg::addrT fetchAddr);
    int waited;
    waited = 0;
    addr = fetchAddr;
    valid = 1'b1;
    while (!(addrOk && stallN)) begin
      @(negedge clk);
      waited++;
      if (waited > acceptTimeout) begin
        failRun("fetch was not accepted in time");
      end
    end
    pending.push_back(fetchAddr);
    @(negedge clk);
  endtask

  task automatic drain();
    int cycles;
    cycles = 0;
    valid = 1'b0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > drainTimeout) begin
        failRun("answers did not arrive in time");
      end
    end while (pending.size() != 0);
    @(negedge clk);
  endtask

  initial begin
    cachePkg::addrT lineA;
    cachePkg::addrT lineB;
    cachePkg::addrT lineC;
    cachePkg::addrT randAddr;
    int refillsBefore;
    int notOkBefore;
    int tagSel;
    int setSel;
    int wordSel;
    int i;
    void'($urandom(63506));
    rst_n = 1'b0;
    addr = '0;
    valid = 1'b0;
    stallN = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // quiet after reset
    repeat (4) begin
      @(negedge clk);
      checkValue("addrOk_o", 64'(addrOk), 64'd1);
      checkValue("dataOk_o", 64'(dataOk), 64'd0);
      checkValue("dataNotOk_o", 64'(dataNotOk), 64'd0);
      checkValue("refillValid_o", 64'(refillValid), 64'd0);
    end

    // cold miss
    lineA = 32'h0000_1000;
    refillsBefore = refillCount;
    notOkBefore = notOkCycles;
    fetch(lineA + 32'h8);
    drain();
    checkValue("refillValid_o pulses", 64'(refillCount - refillsBefore), 64'd1);
    checkValue("refillAddr_o", 64'(lastRefillAddr), 64'(lineOf(lineA + 32'h8)));
    if (notOkCycles == notOkBefore) begin
      failRun("dataNotOk_o never rose during the miss");
    end

    // rest of the line, back to back
    refillsBefore = refillCount;
    fetch(lineA);
    fetch(lineA + 32'h10);
    fetch(lineA + 32'h18);
    drain();
    checkValue("refillValid_o pulses", 64'(refillCount - refillsBefore), 64'd0);
    if (okRunMax < 3) begin
      failRun("hits on a filled line were not answered every cycle");
    end

    // second line in the same set goes to the empty way
    lineB = lineA + (32'h1 << (cachePkg::offsetBits + cachePkg::indexBits));
    refillsBefore = refillCount;
    fetch(lineB + 32'h10);
    drain();
    checkValue("refillValid_o pulses", 64'(refillCount - refillsBefore), 64'd1);
    refillsBefore = refillCount;
    for (i = 0; i < 4; i++) begin
      fetch(lineA + cachePkg::addrT'(i * 8));
      fetch(lineB + cachePkg::addrT'(i * 8));
    end
    drain();
    checkValue("refillValid_o pulses", 64'(refillCount - refillsBefore), 64'd0);

    // four tags over four sets, so ways get evicted
    refillsBefore = refillCount;
    for (i = 0; i < randomFetches; i++) begin
      tagSel = $urandom() % 4;
      setSel = $urandom() % 4;
      wordSel = $urandom() % 4;
      randAddr = 32'h0004_0000
               | (cachePkg::addrT'(tagSel) << (cachePkg::offsetBits + cachePkg::indexBits))
               | (cachePkg::addrT'(setSel) << cachePkg::offsetBits)
               | (cachePkg::addrT'(wordSel) << 3);
      touched[lineOf(randAddr)] = 1'b1;
      fetch(randAddr);
      if ($urandom() % 4 == 0) begin
        valid = 1'b0;
        @(negedge clk);
      end
    end
    drain();
    if (refillCount - refillsBefore < touched.num()) begin
      failRun("fewer refills than distinct lines in the random phase");
    end

    // a hit is answered even though the pipeline stalls right after it
    lineC = 32'h0000_2020;
    refillsBefore = refillCount;
    fetch(randAddr);
    stallN = 1'b0;
    addr = lineC;
    valid = 1'b1;
    repeat (6) begin
      @(negedge clk);
      checkValue("dataOk_o", 64'(dataOk), 64'd0);
    end
    checkValue("refillValid_o pulses", 64'(refillCount - refillsBefore), 64'd0);
    checkValue("pending fetches", 64'(pending.size()), 64'd0);
    stallN = 1'b1;
    fetch(lineC);
    drain();
    checkValue("refillValid_o pulses", 64'(refillCount - refillsBefore), 64'd1);

    if (pending.size() != 0) begin
      failRun("fetches left unanswered at the end of the run");
    end else begin
      $display("All tests passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
cachePkg.sv
busPkg.sv
syncRam.sv
hitSelect.sv
refillBuffer.sv
icacheCtrl.sv
icacheTop.sv
tbMemModel.sv
tbIcache.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --timing --assert
TOP       := tbIcache
FILELIST  := verilog.f
OBJDIR    := obj_dir
PASSMSG   := All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)
